//--- src/noc_link_pkg.sv
package noc_link_pkg;

  // Link flit payload and the wide manycore packet widths.
  localparam int link_width_gp = 16;
  localparam int addr_width_gp = 32;
  localparam int data_width_gp = 32;

  localparam int fwd_width_gp = addr_width_gp + data_width_gp;
  localparam int rev_width_gp = data_width_gp;

  // Each wide packet is cut into a whole number of link flits.
  localparam int fwd_flits_gp = fwd_width_gp / link_width_gp;
  localparam int rev_flits_gp = rev_width_gp / link_width_gp;

  // The channel tag doubles as the index of the credit and token bits.
  typedef enum logic
  {
    CHAN_FWD = 1'b0,
    CHAN_REV = 1'b1
  } chan_e;

  typedef struct packed
  {
    chan_e                    chan;
    logic [link_width_gp-1:0] data;
  } link_flit_s;

  typedef struct packed
  {
    logic [addr_width_gp-1:0] addr;
    logic [data_width_gp-1:0] data;
  } mc_fwd_pkt_s;

  typedef struct packed
  {
    logic [data_width_gp-1:0] data;
  } mc_rev_pkt_s;

  // In the deserializer SER_SEND means a full packet is on offer.
  typedef enum logic
  {
    SER_IDLE = 1'b0,
    SER_SEND = 1'b1
  } ser_state_e;

endpackage

//--- src/wide_to_narrow_link.sv
`timescale 1ns/100ps

module wide_to_narrow_link
 #(parameter int                  width_p = noc_link_pkg::fwd_width_gp
  ,parameter int                  flits_p = noc_link_pkg::fwd_flits_gp
  ,parameter noc_link_pkg::chan_e chan_p  = noc_link_pkg::CHAN_FWD
  )
  (input                            core_clk_i
  ,input                            rst_i

  ,input                            v_i
  ,input        [width_p-1:0]       data_i
  ,output logic                     ready_o

  ,output logic                     flit_v_o
  ,output noc_link_pkg::link_flit_s flit_o
  ,input                            flit_ready_i
  );

  localparam int cnt_width_lp = (flits_p > 1) ? $clog2(flits_p) : 1;

  noc_link_pkg::ser_state_e state_r;
  logic [cnt_width_lp-1:0]  cnt_r;
  logic [width_p-1:0]       data_r;
  logic                     flit_done;

  assign ready_o   = (state_r == noc_link_pkg::SER_IDLE);
  assign flit_v_o  = (state_r == noc_link_pkg::SER_SEND);
  assign flit_done = flit_v_o && flit_ready_i;

  // The low slice of the shift register is always the next flit.
  always_comb
  begin
    flit_o.chan = chan_p;
    flit_o.data = data_r[noc_link_pkg::link_width_gp-1:0];
  end

  always_ff @(posedge core_clk_i)
  begin
    if (rst_i)
    begin
      state_r <= noc_link_pkg::SER_IDLE;
      cnt_r   <= '0;
    end
    else if (v_i && ready_o)
    begin
      state_r <= noc_link_pkg::SER_SEND;
      cnt_r   <= '0;
    end
    else if (flit_done)
    begin
      cnt_r <= cnt_r + 1'b1;
      if (cnt_r == cnt_width_lp'(flits_p - 1))
      begin
        state_r <= noc_link_pkg::SER_IDLE;
      end
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    if (v_i && ready_o)
      data_r <= data_i;
    else if (flit_done)
      data_r <= data_r >> noc_link_pkg::link_width_gp;
  end

endmodule

//--- src/channel_tunnel_mux.sv
`timescale 1ns/100ps

module channel_tunnel_mux
 #(parameter int credits_p = 4
  )
  (input                            core_clk_i
  ,input                            rst_i

  ,input                            fwd_flit_v_i
  ,input  noc_link_pkg::link_flit_s fwd_flit_i
  ,output logic                     fwd_flit_ready_o

  ,input                            rev_flit_v_i
  ,input  noc_link_pkg::link_flit_s rev_flit_i
  ,output logic                     rev_flit_ready_o

  ,output logic                     link_v_o
  ,output noc_link_pkg::link_flit_s link_flit_o
  ,input        [1:0]               link_token_i
  );

  localparam int cnt_width_lp = $clog2(credits_p + 1);

  logic [1:0][cnt_width_lp-1:0]   credit_r;
  noc_link_pkg::chan_e            last_r;
  noc_link_pkg::chan_e            grant;
  logic                           grant_v;
  logic [1:0]                     in_v;
  logic [1:0]                     elig;
  logic [1:0]                     send;
  noc_link_pkg::link_flit_s [1:0] in_flit;

  // Bit 0 is the forward channel, matching the chan_e encoding.
  assign in_v    = {rev_flit_v_i, fwd_flit_v_i};
  assign in_flit = {rev_flit_i, fwd_flit_i};

  assign fwd_flit_ready_o = send[noc_link_pkg::CHAN_FWD];
  assign rev_flit_ready_o = send[noc_link_pkg::CHAN_REV];

  always_comb
  begin
    for (int c = 0; c < 2; c++)
    begin
      elig[c] = in_v[c] && (credit_r[c] != '0);
    end
    grant_v = |elig;

    // On a tie the channel that did not win last time goes first.
    if (&elig)
      grant = (last_r == noc_link_pkg::CHAN_FWD) ? noc_link_pkg::CHAN_REV
                                                 : noc_link_pkg::CHAN_FWD;
    else if (elig[noc_link_pkg::CHAN_REV])
      grant = noc_link_pkg::CHAN_REV;
    else
      grant = noc_link_pkg::CHAN_FWD;

    send        = '0;
    send[grant] = grant_v;
  end

  always_ff @(posedge core_clk_i)
  begin
    if (rst_i)
    begin
      link_v_o <= 1'b0;
      last_r   <= noc_link_pkg::CHAN_REV;
      credit_r <= {2{cnt_width_lp'(credits_p)}};
    end
    else
    begin
      link_v_o <= grant_v;
      if (grant_v)
        last_r <= grant;
      for (int c = 0; c < 2; c++)
      begin
        credit_r[c] <= credit_r[c] - cnt_width_lp'(send[c]) + cnt_width_lp'(link_token_i[c]);
      end
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    if (grant_v)
      link_flit_o <= in_flit[grant];
  end

endmodule

//--- src/channel_tunnel_demux.sv
`timescale 1ns/100ps

module channel_tunnel_demux
 #(parameter int credits_p = 4
  )
  (input                            core_clk_i
  ,input                            rst_i

  ,input                            link_v_i
  ,input  noc_link_pkg::link_flit_s link_flit_i
  ,output logic [1:0]               link_token_o

  ,output logic                     fwd_flit_v_o
  ,output noc_link_pkg::link_flit_s fwd_flit_o
  ,input                            fwd_flit_ready_i

  ,output logic                     rev_flit_v_o
  ,output noc_link_pkg::link_flit_s rev_flit_o
  ,input                            rev_flit_ready_i
  );

  localparam int ptr_width_lp = (credits_p > 1) ? $clog2(credits_p) : 1;
  localparam int cnt_width_lp = $clog2(credits_p + 1);

  logic [noc_link_pkg::link_width_gp-1:0] mem_r [2][credits_p];
  logic [1:0][ptr_width_lp-1:0]           wr_ptr_r;
  logic [1:0][ptr_width_lp-1:0]           rd_ptr_r;
  logic [1:0][cnt_width_lp-1:0]           count_r;
  logic [1:0]                             out_ready;
  logic [1:0]                             wr_en;
  logic [1:0]                             rd_en;

  function automatic logic [ptr_width_lp-1:0] ptr_next(input logic [ptr_width_lp-1:0] ptr);
    ptr_next = (ptr == ptr_width_lp'(credits_p - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign out_ready = {rev_flit_ready_i, fwd_flit_ready_i};

  always_comb
  begin
    for (int c = 0; c < 2; c++)
    begin
      wr_en[c] = link_v_i && (link_flit_i.chan == noc_link_pkg::chan_e'(c));
      rd_en[c] = (count_r[c] != '0) && out_ready[c];
    end
  end

  assign fwd_flit_v_o = (count_r[noc_link_pkg::CHAN_FWD] != '0);
  assign rev_flit_v_o = (count_r[noc_link_pkg::CHAN_REV] != '0);

  always_comb
  begin
    fwd_flit_o.chan = noc_link_pkg::CHAN_FWD;
    fwd_flit_o.data = mem_r[noc_link_pkg::CHAN_FWD][rd_ptr_r[noc_link_pkg::CHAN_FWD]];
    rev_flit_o.chan = noc_link_pkg::CHAN_REV;
    rev_flit_o.data = mem_r[noc_link_pkg::CHAN_REV][rd_ptr_r[noc_link_pkg::CHAN_REV]];
  end

  // The far end trusts its credits, so a write never meets a full FIFO.
  always_ff @(posedge core_clk_i)
  begin
    for (int c = 0; c < 2; c++)
    begin
      if (wr_en[c])
        mem_r[c][wr_ptr_r[c]] <= link_flit_i.data;
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    if (rst_i)
    begin
      wr_ptr_r     <= '0;
      rd_ptr_r     <= '0;
      count_r      <= '0;
      link_token_o <= '0;
    end
    else
    begin
      link_token_o <= rd_en;
      for (int c = 0; c < 2; c++)
      begin
        if (wr_en[c])
          wr_ptr_r[c] <= ptr_next(wr_ptr_r[c]);
        if (rd_en[c])
          rd_ptr_r[c] <= ptr_next(rd_ptr_r[c]);
        count_r[c] <= count_r[c] + cnt_width_lp'(wr_en[c]) - cnt_width_lp'(rd_en[c]);
      end
    end
  end

endmodule

//--- src/narrow_to_wide_link.sv
`timescale 1ns/100ps

module narrow_to_wide_link
 #(parameter int width_p = noc_link_pkg::fwd_width_gp
  ,parameter int flits_p = noc_link_pkg::fwd_flits_gp
  )
  (input                            core_clk_i
  ,input                            rst_i

  ,input                            flit_v_i
  ,input  noc_link_pkg::link_flit_s flit_i
  ,output logic                     flit_ready_o

  ,output logic                     v_o
  ,output logic [width_p-1:0]       data_o
  ,input                            ready_i
  );

  localparam int cnt_width_lp = (flits_p > 1) ? $clog2(flits_p) : 1;

  noc_link_pkg::ser_state_e state_r;
  logic [cnt_width_lp-1:0]  cnt_r;
  logic [width_p-1:0]       data_r;
  logic                     flit_done;

  assign flit_ready_o = (state_r == noc_link_pkg::SER_IDLE);
  assign v_o          = (state_r == noc_link_pkg::SER_SEND);
  assign data_o       = data_r;
  assign flit_done    = flit_v_i && flit_ready_o;

  always_ff @(posedge core_clk_i)
  begin
    if (rst_i)
    begin
      state_r <= noc_link_pkg::SER_IDLE;
      cnt_r   <= '0;
    end
    else if (flit_done)
    begin
      if (cnt_r == cnt_width_lp'(flits_p - 1))
      begin
        state_r <= noc_link_pkg::SER_SEND;
        cnt_r   <= '0;
      end
      else
      begin
        cnt_r <= cnt_r + 1'b1;
      end
    end
    else if (v_o && ready_i)
    begin
      state_r <= noc_link_pkg::SER_IDLE;
    end
  end

  // Flits enter at the top so the first one ends up in the low slice.
  always_ff @(posedge core_clk_i)
  begin
    if (flit_done)
      data_r <= {flit_i.data, data_r[width_p-1:noc_link_pkg::link_width_gp]};
  end

endmodule

//--- src/gateway_noc_io_link.sv
`timescale 1ns/100ps

module gateway_noc_io_link
 #(parameter int credits_p = 4
  )
  (input                             core_clk_i
  ,input                             rst_i

  ,input                             fwd_v_i
  ,input  noc_link_pkg::mc_fwd_pkt_s fwd_pkt_i
  ,output logic                      fwd_ready_o

  ,input                             rev_v_i
  ,input  noc_link_pkg::mc_rev_pkt_s rev_pkt_i
  ,output logic                      rev_ready_o

  ,output logic                      fwd_v_o
  ,output noc_link_pkg::mc_fwd_pkt_s fwd_pkt_o
  ,input                             fwd_ready_i

  ,output logic                      rev_v_o
  ,output noc_link_pkg::mc_rev_pkt_s rev_pkt_o
  ,input                             rev_ready_i

  ,output logic                      link_v_o
  ,output noc_link_pkg::link_flit_s  link_flit_o
  ,input        [1:0]                link_token_i

  ,input                             link_v_i
  ,input  noc_link_pkg::link_flit_s  link_flit_i
  ,output logic [1:0]                link_token_o
  );

  logic                     fwd_tx_v, fwd_tx_ready;
  logic                     rev_tx_v, rev_tx_ready;
  noc_link_pkg::link_flit_s fwd_tx_flit, rev_tx_flit;

  logic                     fwd_rx_v, fwd_rx_ready;
  logic                     rev_rx_v, rev_rx_ready;
  noc_link_pkg::link_flit_s fwd_rx_flit, rev_rx_flit;

  // Transmit path.
  wide_to_narrow_link
 #(.width_p     (noc_link_pkg::fwd_width_gp)
  ,.flits_p     (noc_link_pkg::fwd_flits_gp)
  ,.chan_p      (noc_link_pkg::CHAN_FWD)
  ) fwd_ser
  (.core_clk_i  (core_clk_i)
  ,.rst_i       (rst_i)
  ,.v_i         (fwd_v_i)
  ,.data_i      (fwd_pkt_i)
  ,.ready_o     (fwd_ready_o)
  ,.flit_v_o    (fwd_tx_v)
  ,.flit_o      (fwd_tx_flit)
  ,.flit_ready_i(fwd_tx_ready)
  );

  wide_to_narrow_link
 #(.width_p     (noc_link_pkg::rev_width_gp)
  ,.flits_p     (noc_link_pkg::rev_flits_gp)
  ,.chan_p      (noc_link_pkg::CHAN_REV)
  ) rev_ser
  (.core_clk_i  (core_clk_i)
  ,.rst_i       (rst_i)
  ,.v_i         (rev_v_i)
  ,.data_i      (rev_pkt_i)
  ,.ready_o     (rev_ready_o)
  ,.flit_v_o    (rev_tx_v)
  ,.flit_o      (rev_tx_flit)
  ,.flit_ready_i(rev_tx_ready)
  );

  channel_tunnel_mux
 #(.credits_p       (credits_p)
  ) tunnel_tx
  (.core_clk_i      (core_clk_i)
  ,.rst_i           (rst_i)
  ,.fwd_flit_v_i    (fwd_tx_v)
  ,.fwd_flit_i      (fwd_tx_flit)
  ,.fwd_flit_ready_o(fwd_tx_ready)
  ,.rev_flit_v_i    (rev_tx_v)
  ,.rev_flit_i      (rev_tx_flit)
  ,.rev_flit_ready_o(rev_tx_ready)
  ,.link_v_o        (link_v_o)
  ,.link_flit_o     (link_flit_o)
  ,.link_token_i    (link_token_i)
  );

  // Receive path.
  channel_tunnel_demux
 #(.credits_p       (credits_p)
  ) tunnel_rx
  (.core_clk_i      (core_clk_i)
  ,.rst_i           (rst_i)
  ,.link_v_i        (link_v_i)
  ,.link_flit_i     (link_flit_i)
  ,.link_token_o    (link_token_o)
  ,.fwd_flit_v_o    (fwd_rx_v)
  ,.fwd_flit_o      (fwd_rx_flit)
  ,.fwd_flit_ready_i(fwd_rx_ready)
  ,.rev_flit_v_o    (rev_rx_v)
  ,.rev_flit_o      (rev_rx_flit)
  ,.rev_flit_ready_i(rev_rx_ready)
  );

  narrow_to_wide_link
 #(.width_p     (noc_link_pkg::fwd_width_gp)
  ,.flits_p     (noc_link_pkg::fwd_flits_gp)
  ) fwd_deser
  (.core_clk_i  (core_clk_i)
  ,.rst_i       (rst_i)
  ,.flit_v_i    (fwd_rx_v)
  ,.flit_i      (fwd_rx_flit)
  ,.flit_ready_o(fwd_rx_ready)
  ,.v_o         (fwd_v_o)
  ,.data_o      (fwd_pkt_o)
  ,.ready_i     (fwd_ready_i)
  );

  narrow_to_wide_link
 #(.width_p     (noc_link_pkg::rev_width_gp)
  ,.flits_p     (noc_link_pkg::rev_flits_gp)
  ) rev_deser
  (.core_clk_i  (core_clk_i)
  ,.rst_i       (rst_i)
  ,.flit_v_i    (rev_rx_v)
  ,.flit_i      (rev_rx_flit)
  ,.flit_ready_o(rev_rx_ready)
  ,.v_o         (rev_v_o)
  ,.data_o      (rev_pkt_o)
  ,.ready_i     (rev_ready_i)
  );

endmodule

//--- sim/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen
 #(parameter int period_p = 40
  )
  (output logic clk_o
  );

  initial
  begin
    clk_o = 1'b0;
    forever #(period_p / 2) clk_o = ~clk_o;
  end

endmodule

//--- sim/gateway_noc_io_link_props.sv
`timescale 1ns/100ps

module gateway_noc_io_link_props
 #(parameter int credits_p = 4
  )
  (input                                    core_clk_i
  ,input                                    rst_i
  ,input                                    fwd_v_i
  ,input                                    rev_v_i
  ,input [1:0][$clog2(credits_p + 1)-1:0]   credit_i
  ,input                                    link_v_i
  ,input noc_link_pkg::link_flit_s          link_flit_i
  ,input [1:0]                              link_token_i
  );

  localparam int cnt_width_lp = $clog2(credits_p + 1);

  // Flits seen on the link whose receive slot has not come back as a token.
  logic [1:0][cnt_width_lp-1:0] pending_r;
  logic [1:0]                   link_sent;

  assign link_sent[0] = link_v_i && (link_flit_i.chan == noc_link_pkg::CHAN_FWD);
  assign link_sent[1] = link_v_i && (link_flit_i.chan == noc_link_pkg::CHAN_REV);

  always_ff @(posedge core_clk_i)
  begin
    if (rst_i)
      pending_r <= '0;
    else
    begin
      for (int c = 0; c < 2; c++)
      begin
        pending_r[c] <= pending_r[c] + cnt_width_lp'(link_sent[c])
                        - cnt_width_lp'(link_token_i[c]);
      end
    end
  end

  fwd_send_has_credit: assert property (@(posedge core_clk_i) disable iff (rst_i)
    link_sent[0] |-> (pending_r[0] < cnt_width_lp'(credits_p)))
    else $error("Forward flit sent while the far end had no free slot for it.");

  rev_send_has_credit: assert property (@(posedge core_clk_i) disable iff (rst_i)
    link_sent[1] |-> (pending_r[1] < cnt_width_lp'(credits_p)))
    else $error("Return flit sent while the far end had no free slot for it.");

  credit_bounded: assert property (@(posedge core_clk_i) disable iff (rst_i)
    (credit_i[0] <= cnt_width_lp'(credits_p)) && (credit_i[1] <= cnt_width_lp'(credits_p)))
    else $error("Credit count rose above the receive FIFO depth.");

  link_idle_after_reset: assert property (@(posedge core_clk_i)
    rst_i |=> !link_v_i)
    else $error("Link valid high in the cycle after reset.");

  // When both channels compete, the winner differs from the previous grant.
  grant_alternates: assert property (@(posedge core_clk_i) disable iff (rst_i)
    (fwd_v_i && rev_v_i && (credit_i[0] != '0) && (credit_i[1] != '0) && link_v_i)
    |=> (link_flit_i.chan != $past(link_flit_i.chan)))
    else $error("Round-robin grant did not alternate between waiting channels.");

endmodule

bind channel_tunnel_mux gateway_noc_io_link_props
 #(.credits_p   (credits_p)
  ) mux_props
  (.core_clk_i  (core_clk_i)
  ,.rst_i       (rst_i)
  ,.fwd_v_i     (fwd_flit_v_i)
  ,.rev_v_i     (rev_flit_v_i)
  ,.credit_i    (credit_r)
  ,.link_v_i    (link_v_o)
  ,.link_flit_i (link_flit_o)
  ,.link_token_i(link_token_i)
  );

//--- sim/gateway_noc_io_link_tb.sv
`timescale 1ns/100ps

module gateway_noc_io_link_tb;

  localparam int credits_lp    = 4;
  localparam int stall_limit_lp = credits_lp + noc_link_pkg::fwd_flits_gp;

  logic                      clk;
  logic                      rst;
  logic                      fwd_in_v, fwd_in_ready, rev_in_v, rev_in_ready;
  noc_link_pkg::mc_fwd_pkt_s fwd_in_pkt, fwd_out_pkt;
  noc_link_pkg::mc_rev_pkt_s rev_in_pkt, rev_out_pkt;
  logic                      fwd_out_v, fwd_out_ready, rev_out_v, rev_out_ready;
  logic                      link_v;
  noc_link_pkg::link_flit_s  link_flit;
  logic [1:0]                link_token;

  logic [63:0] fwd_send_q[$];
  logic [31:0] rev_send_q[$];
  int          fwd_stall_q[$];
  int          rev_stall_q[$];
  logic [63:0] fwd_exp_q[$];
  logic [31:0] rev_exp_q[$];

  int   seed = 64630;
  int   test_lines = 0;
  int   cycle_count = 0;
  int   cycle_limit = 0;
  logic fwd_stalling = 1'b0;
  int   fwd_stall_flits = 0;

  tb_clock_gen #(.period_p(40)) clock_gen (.clk_o(clk));

  // The link is looped back, so the DUT receives its own flits and tokens.
  gateway_noc_io_link #(.credits_p(credits_lp)) uut
    (.core_clk_i(clk), .rst_i(rst)
    ,.fwd_v_i(fwd_in_v), .fwd_pkt_i(fwd_in_pkt), .fwd_ready_o(fwd_in_ready)
    ,.rev_v_i(rev_in_v), .rev_pkt_i(rev_in_pkt), .rev_ready_o(rev_in_ready)
    ,.fwd_v_o(fwd_out_v), .fwd_pkt_o(fwd_out_pkt), .fwd_ready_i(fwd_out_ready)
    ,.rev_v_o(rev_out_v), .rev_pkt_o(rev_out_pkt), .rev_ready_i(rev_out_ready)
    ,.link_v_o(link_v), .link_flit_o(link_flit), .link_token_i(link_token)
    ,.link_v_i(link_v), .link_flit_i(link_flit), .link_token_o(link_token)
    );

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at time %0t: %s", $time, msg);
    $display("TESTS FAILED");
    $fatal(1, "Stopped at the first mismatch.");
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "Run aborted.");
  endtask

  task automatic check_idle_outputs;
    assert (!link_v && (link_token == 2'b00) && !fwd_out_v && !rev_out_v)
      else report_mismatch("an output is active during or right after reset");
    assert (fwd_in_ready && rev_in_ready)
      else report_mismatch("a serializer is not ready during or right after reset");
  endtask

  task automatic load_tests;
    int          fd;
    int          r;
    int          chan;
    int          stall;
    logic [63:0] pay;
    string       line;
    fd = $fopen("sim/link_tests.txt", "r");
    if (fd == 0)
      abort_run("Could not open sim/link_tests.txt for reading.");
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        r = $fgets(line, fd);
        if (r == 0 || line.len() == 0 || line[0] == "#")
          continue;
        r = $sscanf(line, "%d %h %d", chan, pay, stall);
        if (r != 3)
          continue;
        test_lines++;
        // Stalls get a small random extension, drawn in file order.
        if (stall > 0)
          stall = stall + ($random(seed) & 3);
        if (chan == 0)
        begin
          fwd_send_q.push_back(pay);
          fwd_stall_q.push_back(stall);
        end
        else
        begin
          rev_send_q.push_back(pay[31:0]);
          rev_stall_q.push_back(stall);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic send_fwd;
    foreach (fwd_send_q[i])
    begin
      @(negedge clk);
      fwd_in_v   = 1'b1;
      fwd_in_pkt = noc_link_pkg::mc_fwd_pkt_s'(fwd_send_q[i]);
      do @(posedge clk); while (!fwd_in_ready);
      fwd_exp_q.push_back(fwd_send_q[i]);
    end
    @(negedge clk);
    fwd_in_v = 1'b0;
  endtask

  task automatic send_rev;
    foreach (rev_send_q[i])
    begin
      @(negedge clk);
      rev_in_v   = 1'b1;
      rev_in_pkt = noc_link_pkg::mc_rev_pkt_s'(rev_send_q[i]);
      do @(posedge clk); while (!rev_in_ready);
      rev_exp_q.push_back(rev_send_q[i]);
    end
    @(negedge clk);
    rev_in_v = 1'b0;
  endtask

  task automatic receive_fwd;
    int          n;
    logic [63:0] exp;
    foreach (fwd_stall_q[i])
    begin
      n = fwd_stall_q[i];
      if (n > 0)
      begin
        @(negedge clk);
        fwd_out_ready   = 1'b0;
        fwd_stalling    = 1'b1;
        fwd_stall_flits = 0;
        repeat (n) @(negedge clk);
        fwd_out_ready = 1'b1;
        fwd_stalling  = 1'b0;
      end
      do @(posedge clk); while (!fwd_out_v);
      assert (fwd_exp_q.size() > 0)
        else report_mismatch("forward packet arrived before it was sent");
      exp = fwd_exp_q.pop_front();
      assert ({fwd_out_pkt.addr, fwd_out_pkt.data} == exp)
        else report_mismatch($sformatf("forward packet %0d is %h_%h, expected %h",
                                       i, fwd_out_pkt.addr, fwd_out_pkt.data, exp));
    end
  endtask

  task automatic receive_rev;
    int          n;
    logic [31:0] exp;
    foreach (rev_stall_q[i])
    begin
      n = rev_stall_q[i];
      if (n > 0)
      begin
        @(negedge clk);
        rev_out_ready = 1'b0;
        repeat (n) @(negedge clk);
        rev_out_ready = 1'b1;
      end
      do @(posedge clk); while (!rev_out_v);
      assert (rev_exp_q.size() > 0)
        else report_mismatch("return packet arrived before it was sent");
      exp = rev_exp_q.pop_front();
      assert (rev_out_pkt.data == exp)
        else report_mismatch($sformatf("return packet %0d is %h, expected %h",
                                       i, rev_out_pkt.data, exp));
    end
  endtask

  // A held forward packet plus a full FIFO bound the flits sent during a stall.
  always @(posedge clk)
  begin
    if (fwd_stalling && link_v && (link_flit.chan == noc_link_pkg::CHAN_FWD))
    begin
      fwd_stall_flits = fwd_stall_flits + 1;
      assert (fwd_stall_flits <= stall_limit_lp)
        else report_mismatch($sformatf("%0d forward flits in one stall, limit %0d",
                                       fwd_stall_flits, stall_limit_lp));
    end
  end

  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count > cycle_limit)
      abort_run($sformatf("Timeout after %0d cycles, packets are still in flight.", cycle_count));
  end

  initial
  begin
    rst           = 1'b1;
    fwd_in_v      = 1'b0;
    fwd_in_pkt    = '0;
    rev_in_v      = 1'b0;
    rev_in_pkt    = '0;
    fwd_out_ready = 1'b1;
    rev_out_ready = 1'b1;
    load_tests();
    cycle_limit = 30 * test_lines + 200;

    repeat (10)
    begin
      @(negedge clk);
      check_idle_outputs();
    end
    rst = 1'b0;
    @(negedge clk);
    check_idle_outputs();

    fork
      send_fwd();
      send_rev();
      receive_fwd();
      receive_rev();
    join

    if (fwd_exp_q.size() == 0 && rev_exp_q.size() == 0)
    begin
      $display("TESTS PASSED");
      $finish;
    end
    else
      abort_run($sformatf("Packets are missing: %0d forward and %0d return never arrived.",
                          fwd_exp_q.size(), rev_exp_q.size()));
  end

endmodule

//--- sim/link_tests.txt
# chan (0 forward, 1 return)  payload in hex (forward is addr then data)  stall cycles
# The stall holds the matching output ready low before that packet is taken.
0 0000100000000001 0
0 0000100400000002 0
1 a5a50001 0
0 0000100800000003 0
1 a5a50002 0
1 a5a50003 2
0 0000100c00000004 3
1 5a5a0004 0
0 0000201000000005 40
1 5a5a0005 0
1 5a5a0006 1
0 0000201400000006 0
1 c3c30007 0
0 0000201800000007 0
1 c3c30008 5
0 0000201c00000008 0
1 c3c30009 0
1 3c3c000a 0
0 deadbeefcafef00d 2
1 3c3c000b 0
0 ffffffff00000000 0
1 3c3c000c 6
0 00000000ffffffff 0
1 0f0f000d 0
0 123456789abcdef0 4
1 0f0f000e 0
1 f0f0000f 12
0 0fedcba987654321 0
1 f0f00010 0
0 8000000000000001 0

//--- sources.f
src/noc_link_pkg.sv
src/wide_to_narrow_link.sv
src/channel_tunnel_mux.sv
src/channel_tunnel_demux.sv
src/narrow_to_wide_link.sv
src/gateway_noc_io_link.sv
sim/tb_clock_gen.sv
sim/gateway_noc_io_link_props.sv
sim/gateway_noc_io_link_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds and runs the testbench; the exit status is the simulation result.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module gateway_noc_io_link_tb \
  -f sources.f -Mdir obj_dir \
  && ./obj_dir/Vgateway_noc_io_link_tb \
  || { echo "Simulation failed." >&2; exit 1; }
